// ==== dac_ctrl_cfg.svh ====
////////////////////////////////////////////////////////////
// AD5601 DAC controller constants: bus widths, SPI timing,
// register map and reset values
////////////////////////////////////////////////////////////

`ifndef DAC_CTRL_CFG_SVH
`define DAC_CTRL_CFG_SVH

// APB bus
`define DAC_APB_ADDR_W      8
`define DAC_APB_DATA_W      16

// register byte addresses
`define DAC_ADDR_VERSION    8'h00
`define DAC_ADDR_DAC_REG    8'h04
`define DAC_ADDR_CTRL       8'h08

// reset and identification values
`define DAC_MODULE_VERSION  16'd1
`define DAC_DEFAULT         16'd100

// SPI frame timing, sclk divider must be even
`define DAC_FRAME_BITS      16
`define DAC_SCLK_DIV        4
`define DAC_SYNC_GAP        4

// gain field position inside the DAC input register
`define DAC_GAIN_LSB        6
`define DAC_GAIN_W          8

`endif

// ==== dac_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types for the AD5601 DAC controller
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

package dac_ctrl_pkg;

    // APB request from the host
    typedef struct packed {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`DAC_APB_ADDR_W-1:0]  paddr;
        logic [`DAC_APB_DATA_W-1:0]  pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        logic [`DAC_APB_DATA_W-1:0]  prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

    // AD5601 input register layout, power-down mode on top
    typedef struct packed {
        logic [`DAC_FRAME_BITS-`DAC_GAIN_W-`DAC_GAIN_LSB-1:0] pd_mode;
        logic [`DAC_GAIN_W-1:0]                               gain;
        logic [`DAC_GAIN_LSB-1:0]                             rsvd;
    } dac_word_t;

    // serial pins toward the DAC
    typedef struct packed {
        logic sclk;
        logic sync_n;
        logic mosi;
    } spi_pins_t;

endpackage

// ==== dac_regfile.sv ====
////////////////////////////////////////////////////////////
// APB register block: version, DAC word and control status,
// with host or gain-input ownership of the DAC word
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module dac_regfile (
    input  logic                         clk,
    input  logic                         interconnect_sreset,
    input  dac_ctrl_pkg::apb_req_t       apb_req,
    output dac_ctrl_pkg::apb_rsp_t       apb_rsp,
    input  logic                         en_mmi_ctrl,
    input  logic [`DAC_GAIN_W-1:0]       gain,
    input  logic                         gain_valid,
    output dac_ctrl_pkg::dac_word_t      dac_word,
    output logic                         dac_changed,
    output logic                         gain_src
);
    import dac_ctrl_pkg::*;

    dac_word_t dac_reg;
    logic      apb_wr;
    logic      host_dac_wr;
    logic      gain_wr;

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////

    // access phase of a write, commits at the closing edge
    assign apb_wr = apb_req.psel & apb_req.penable & apb_req.pwrite;

    // host owns the DAC word only while en_mmi_ctrl is high
    assign host_dac_wr = apb_wr & en_mmi_ctrl & (apb_req.paddr == `DAC_ADDR_DAC_REG);
    assign gain_wr     = gain_valid & ~en_mmi_ctrl;

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            dac_reg     <= dac_word_t'(`DAC_DEFAULT);
            dac_changed <= 1'b0;
            gain_src    <= 1'b0;
        end else begin
            if (host_dac_wr) begin
                dac_reg <= dac_word_t'(apb_req.pwdata);
            end else if (gain_wr) begin
                // only the gain field moves, mode and reserved bits stay
                dac_reg.gain <= gain;
            end
            // pulse lines up with the new register value
            dac_changed <= host_dac_wr | gain_wr;
            gain_src    <= gain_wr;
        end
    end

    assign dac_word = dac_reg;

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        case (apb_req.paddr)
            `DAC_ADDR_VERSION: apb_rsp.prdata = `DAC_MODULE_VERSION;
            `DAC_ADDR_DAC_REG: apb_rsp.prdata = dac_reg;
            `DAC_ADDR_CTRL: begin
                apb_rsp.prdata = {{(`DAC_APB_DATA_W-1){1'b0}}, en_mmi_ctrl};
            end
            // unmapped space reads zero
            default: apb_rsp.prdata = '0;
        endcase
    end

    // an access cycle must follow a setup cycle to the same slave
    assert property (@(posedge clk) disable iff (interconnect_sreset)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
        else $error("apb penable without a preceding setup cycle");

endmodule

// ==== dac_update_fsm.sv ====
////////////////////////////////////////////////////////////
// DAC update sequencer: merges register changes into SPI
// frames and flags frames that carried a gain update
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module dac_update_fsm (
    input  logic clk,
    input  logic interconnect_sreset,
    input  logic dac_changed,
    input  logic gain_src,
    input  logic frame_done,
    output logic load,
    output logic run,
    output logic sync_n,
    output logic gain_updated
);

    localparam int GAP_W = $clog2(`DAC_SYNC_GAP);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_IDLE,
        ST_SHIFT,
        ST_GAP
    } state_t;

    state_t             state;
    logic               pending;
    logic               pend_src;
    logic               frame_src;
    logic [GAP_W-1:0]   gap_cnt;

    // a change seen in idle is loaded straight away
    assign load = (state == ST_IDLE) & (pending | dac_changed);
    assign run  = ~sync_n;

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            state        <= ST_RESET;
            pending      <= 1'b0;
            pend_src     <= 1'b0;
            frame_src    <= 1'b0;
            gap_cnt      <= '0;
            sync_n       <= 1'b1;
            gain_updated <= 1'b0;
        end else begin
            gain_updated <= 1'b0;

            ////////////////////////////////////////////////////////////
            // pending update bookkeeping
            ////////////////////////////////////////////////////////////
            if (state == ST_RESET) begin
                // default frame after reset
                pending  <= 1'b1;
                pend_src <= 1'b0;
            end else if (load) begin
                pending   <= 1'b0;
                frame_src <= dac_changed ? gain_src : pend_src;
            end else if (dac_changed) begin
                // later changes win, one extra frame carries them
                pending  <= 1'b1;
                pend_src <= gain_src;
            end

            ////////////////////////////////////////////////////////////
            // frame sequencing
            ////////////////////////////////////////////////////////////
            case (state)
                ST_RESET: begin
                    state <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (load) begin
                        state  <= ST_SHIFT;
                        sync_n <= 1'b0;
                    end
                end
                ST_SHIFT: begin
                    if (frame_done) begin
                        state        <= ST_GAP;
                        sync_n       <= 1'b1;
                        gap_cnt      <= '0;
                        gain_updated <= frame_src;
                    end
                end
                ST_GAP: begin
                    if (gap_cnt == GAP_W'(`DAC_SYNC_GAP - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sync_n stays high and no word is loaded for the whole gap
    assert property (@(posedge clk) disable iff (interconnect_sreset)
        $rose(sync_n) |-> (sync_n && !load) [*`DAC_SYNC_GAP])
        else $error("load or sync_n low inside the sync gap");

endmodule

// ==== spi_bit_timer.sv ====
////////////////////////////////////////////////////////////
// SPI bit timer: sclk divider, bit counter, frame end pulse
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module spi_bit_timer (
    input  logic clk,
    input  logic interconnect_sreset,
    input  logic run,
    output logic sclk,
    output logic bit_stb,
    output logic frame_done
);

    localparam int DIV_W = $clog2(`DAC_SCLK_DIV);
    localparam int BIT_W = $clog2(`DAC_FRAME_BITS);

    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             period_end;

    assign period_end = (div_cnt == DIV_W'(`DAC_SCLK_DIV - 1));

    // counters sit at zero outside a frame
    always_ff @(posedge clk) begin
        if (interconnect_sreset || !run) begin
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (period_end) begin
            div_cnt <= '0;
            bit_cnt <= frame_done ? '0 : bit_cnt + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // high first half, low second half, so idle is high
    assign sclk = (div_cnt < DIV_W'(`DAC_SCLK_DIV / 2));

    // sclk rises as the period wraps
    assign bit_stb    = period_end;
    assign frame_done = period_end & (bit_cnt == BIT_W'(`DAC_FRAME_BITS - 1));

    assert property (@(posedge clk) disable iff (interconnect_sreset)
        frame_done |-> run)
        else $error("frame_done outside a running frame");

endmodule

// ==== spi_shift_tx.sv ====
////////////////////////////////////////////////////////////
// SPI transmit shifter, MSB first
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module spi_shift_tx (
    input  logic                     clk,
    input  logic                     interconnect_sreset,
    input  logic                     load,
    input  logic                     bit_stb,
    input  dac_ctrl_pkg::dac_word_t  dac_word,
    output logic                     mosi
);

    logic [`DAC_FRAME_BITS-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            shift_q <= '0;
        end else if (load) begin
            shift_q <= dac_word;
        end else if (bit_stb) begin
            // next bit appears with the rising sclk edge
            shift_q <= {shift_q[`DAC_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign mosi = shift_q[`DAC_FRAME_BITS-1];

endmodule

// ==== dac_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// AD5601 DAC update controller top level
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module dac_ctrl_top (
    input  logic                     clk,
    input  logic                     interconnect_sreset,
    input  dac_ctrl_pkg::apb_req_t   apb_req,
    output dac_ctrl_pkg::apb_rsp_t   apb_rsp,
    input  logic                     en_mmi_ctrl,
    input  logic [`DAC_GAIN_W-1:0]   gain,
    input  logic                     gain_valid,
    output logic                     gain_updated,
    output dac_ctrl_pkg::spi_pins_t  spi
);
    import dac_ctrl_pkg::*;

    dac_word_t dac_word;
    logic      dac_changed;
    logic      gain_src;
    logic      load;
    logic      run;
    logic      sync_n;
    logic      sclk;
    logic      bit_stb;
    logic      frame_done;
    logic      mosi;

    dac_regfile dac_regfile_inst (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .apb_req             (apb_req),
        .apb_rsp             (apb_rsp),
        .en_mmi_ctrl         (en_mmi_ctrl),
        .gain                (gain),
        .gain_valid          (gain_valid),
        .dac_word            (dac_word),
        .dac_changed         (dac_changed),
        .gain_src            (gain_src)
    );

    dac_update_fsm dac_update_fsm_inst (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .dac_changed         (dac_changed),
        .gain_src            (gain_src),
        .frame_done          (frame_done),
        .load                (load),
        .run                 (run),
        .sync_n              (sync_n),
        .gain_updated        (gain_updated)
    );

    spi_bit_timer spi_bit_timer_inst (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .run                 (run),
        .sclk                (sclk),
        .bit_stb             (bit_stb),
        .frame_done          (frame_done)
    );

    spi_shift_tx spi_shift_tx_inst (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .load                (load),
        .bit_stb             (bit_stb),
        .dac_word            (dac_word),
        .mosi                (mosi)
    );

    // pins toward the DAC
    assign spi = '{sclk: sclk, sync_n: sync_n, mosi: mosi};

endmodule

// ==== dac_ctrl_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the AD5601 DAC controller: table-driven APB
// and gain stimulus with an SPI frame monitor
////////////////////////////////////////////////////////////

`include "dac_ctrl_cfg.svh"

module dac_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dac_ctrl_pkg::*;

    localparam int FRAME_CYCLES = `DAC_FRAME_BITS * `DAC_SCLK_DIV;
    localparam int SETTLE       = FRAME_CYCLES + 2 * `DAC_SYNC_GAP + 8;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_GAIN, OP_MODE, OP_WAIT} op_t;

    // for OP_WAIT, data is the frame count and addr the gain_updated count
    typedef struct packed {
        op_t         op;
        logic [7:0]  addr;
        logic [15:0] data;
        logic [15:0] expected;
    } step_t;

    logic      clk = 1'b0;
    logic      interconnect_sreset;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      en_mmi_ctrl;
    logic [7:0] gain;
    logic      gain_valid;
    logic      gain_updated;
    spi_pins_t spi;

    step_t       steps[$];
    int          errors = 0;
    int          checks = 0;
    bit          timed_out = 1'b0;
    int          frame_cnt;
    int          gain_cnt;
    int          cap_bits;
    logic [15:0] cap_word;
    logic [15:0] last_frame;
    logic        prev_sclk;
    logic        prev_sync;

    dac_ctrl_top dac_ctrl_top_inst (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .apb_req             (apb_req),
        .apb_rsp             (apb_rsp),
        .en_mmi_ctrl         (en_mmi_ctrl),
        .gain                (gain),
        .gain_valid          (gain_valid),
        .gain_updated        (gain_updated),
        .spi                 (spi)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // SPI monitor, mosi taken on falling sclk inside a frame
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (interconnect_sreset) begin
            frame_cnt <= 0;
            gain_cnt  <= 0;
            cap_bits  <= 0;
            prev_sclk <= 1'b1;
            prev_sync <= 1'b1;
        end else begin
            prev_sclk <= spi.sclk;
            prev_sync <= spi.sync_n;
            if (!spi.sync_n && prev_sclk && !spi.sclk) begin
                cap_word <= {cap_word[14:0], spi.mosi};
                cap_bits <= cap_bits + 1;
            end
            // rising sync_n closes the frame
            if (!prev_sync && spi.sync_n) begin
                last_frame <= cap_word;
                frame_cnt  <= frame_cnt + 1;
                cap_bits   <= 0;
                if (cap_bits != `DAC_FRAME_BITS) begin
                    $display("frame ended after %0d bits instead of %0d",
                             cap_bits, `DAC_FRAME_BITS);
                    errors++;
                end
            end
            if (gain_updated) begin
                gain_cnt <= gain_cnt + 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus and pin drivers, called right after a falling edge
    ////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        // zero wait states and no slave error
        @(posedge clk);
        check_value("pready", apb_rsp.pready, 1'b1);
        check_value("pslverr", apb_rsp.pslverr, 1'b0);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(negedge clk);
        apb_req.penable = 1'b1;
        // read data and status are taken as the access cycle closes
        @(posedge clk);
        data = apb_rsp.prdata;
        check_value("pready", apb_rsp.pready, 1'b1);
        check_value("pslverr", apb_rsp.pslverr, 1'b0);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic pulse_gain(input logic [7:0] value);
        gain       = value;
        gain_valid = 1'b1;
        @(negedge clk);
        gain_valid = 1'b0;
    endtask

    // waits for n more frames, then idles a full frame to catch a leftover one
    task automatic wait_frames(input int n, input logic [15:0] exp_word, input int exp_gain);
        int target;
        int gain_base;
        int cycles;
        target    = frame_cnt + n;
        gain_base = gain_cnt;
        cycles    = 0;
        while (frame_cnt < target && cycles < (n + 1) * 2 * SETTLE) begin
            @(negedge clk);
            cycles++;
        end
        if (frame_cnt < target) begin
            $display("timed out waiting for %0d SPI frames, saw %0d",
                     n, frame_cnt - (target - n));
            errors++;
            timed_out = 1'b1;
        end else begin
            repeat (SETTLE) @(negedge clk);
            check_value("frame_cnt", frame_cnt, target);
            check_value("spi_frame", last_frame, exp_word);
            check_value("gain_updated_cnt", gain_cnt - gain_base, exp_gain);
        end
    endtask

    function automatic void add_step(input op_t op, input logic [7:0] addr,
                                     input logic [15:0] data, input logic [15:0] expected);
        steps.push_back('{op: op, addr: addr, data: data, expected: expected});
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus table, expected values from a shadow DAC register
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        logic [15:0] shadow;
        logic [15:0] d;
        logic [7:0]  g;
        shadow = `DAC_DEFAULT;
        add_step(OP_WAIT, 8'd0, 16'd1, shadow);
        add_step(OP_READ, `DAC_ADDR_VERSION, '0, `DAC_MODULE_VERSION);
        add_step(OP_READ, `DAC_ADDR_DAC_REG, '0, shadow);
        // host owns the register
        add_step(OP_MODE, 8'd0, 16'd1, '0);
        d = $urandom;
        add_step(OP_WRITE, `DAC_ADDR_DAC_REG, d, '0);
        shadow = d;
        add_step(OP_READ, `DAC_ADDR_DAC_REG, '0, shadow);
        add_step(OP_WAIT, 8'd0, 16'd1, shadow);
        g = $urandom;
        add_step(OP_GAIN, 8'd0, {8'd0, g}, '0);
        add_step(OP_READ, `DAC_ADDR_DAC_REG, '0, shadow);
        add_step(OP_WAIT, 8'd0, 16'd0, shadow);
        // gain input owns the register
        add_step(OP_MODE, 8'd0, 16'd0, '0);
        d = $urandom;
        add_step(OP_WRITE, `DAC_ADDR_DAC_REG, d, '0);
        add_step(OP_READ, `DAC_ADDR_CTRL, '0, 16'd0);
        g = $urandom;
        add_step(OP_GAIN, 8'd0, {8'd0, g}, '0);
        shadow[`DAC_GAIN_LSB +: `DAC_GAIN_W] = g;
        add_step(OP_WAIT, 8'd1, 16'd1, shadow);
        add_step(OP_READ, `DAC_ADDR_DAC_REG, '0, shadow);
        // read-only and unmapped space
        add_step(OP_MODE, 8'd0, 16'd1, '0);
        add_step(OP_READ, `DAC_ADDR_CTRL, '0, 16'd1);
        add_step(OP_WRITE, `DAC_ADDR_VERSION, 16'($urandom), '0);
        add_step(OP_WRITE, `DAC_ADDR_CTRL, 16'($urandom), '0);
        add_step(OP_READ, `DAC_ADDR_VERSION, '0, `DAC_MODULE_VERSION);
        add_step(OP_READ, `DAC_ADDR_CTRL, '0, 16'd1);
        add_step(OP_READ, 8'h0c, '0, 16'd0);
        add_step(OP_READ, 8'h02, '0, 16'd0);
        // burst of writes merges into one extra frame
        repeat (4) begin
            d = $urandom;
            add_step(OP_WRITE, `DAC_ADDR_DAC_REG, d, '0);
            shadow = d;
        end
        add_step(OP_WAIT, 8'd0, 16'd2, shadow);
        add_step(OP_READ, `DAC_ADDR_DAC_REG, '0, shadow);
    endtask

    initial begin
        step_t       step;
        logic [15:0] rdata;
        void'($urandom(32'hef5e_45ce));
        interconnect_sreset = 1'b1;
        apb_req             = '0;
        en_mmi_ctrl         = 1'b0;
        gain                = '0;
        gain_valid          = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        interconnect_sreset = 1'b0;

        foreach (steps[i]) begin
            step = steps[i];
            if (!timed_out) begin
                case (step.op)
                    OP_WRITE: apb_write(step.addr, step.data);
                    OP_READ: begin
                        apb_read(step.addr, rdata);
                        check_value($sformatf("prdata@0x%02h", step.addr), rdata,
                                    step.expected);
                    end
                    OP_GAIN: pulse_gain(step.data[7:0]);
                    OP_MODE: begin
                        en_mmi_ctrl = step.data[0];
                        @(negedge clk);
                    end
                    default: wait_frames(step.data, step.expected, step.addr);
                endcase
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
dac_ctrl_pkg.sv
dac_regfile.sv
dac_update_fsm.sv
spi_bit_timer.sv
spi_shift_tx.sv
dac_ctrl_top.sv
dac_ctrl_tb.sv
